//--- common/capture_pkg.sv
/* capture path constants, word and state enums,
   packed structs for sensor input, capture words and frame status */
`default_nettype none

package capture_pkg;

	// ----------------------------------------------------------------------
	// widths
	// ----------------------------------------------------------------------

	// one sensor pixel
	localparam int PIX_WIDTH = 8;
	// pixels packed into one capture word
	localparam int PIX_PER_WORD = 4;
	// data field of a capture word
	localparam int WORD_WIDTH = PIX_WIDTH * PIX_PER_WORD;
	// lines per frame counter
	localparam int LINE_CNT_WIDTH = 12;

	// ----------------------------------------------------------------------
	// enums
	// ----------------------------------------------------------------------

	// what the data field of an output word carries
	typedef enum logic [1:0] {
		WORD_PIX    = 2'd0,
		WORD_STATUS = 2'd1
	} word_kind_e;

	// merge FSM in the output framer
	typedef enum logic {
		IDLE        = 1'b0,
		HOLD_STATUS = 1'b1
	} framer_state_e;

	// ----------------------------------------------------------------------
	// structs
	// ----------------------------------------------------------------------

	// raw sensor stream, sampled every clock, no handshake
	typedef struct packed {
		logic                 fval;
		logic                 lval;
		logic [PIX_WIDTH-1:0] pix;
	} sensor_in_t;

	// one word toward the receiver
	// first pixel sits in the low byte, short words are zero padded
	typedef struct packed {
		word_kind_e            kind;
		logic                  sof;
		logic                  eol;
		logic [WORD_WIDTH-1:0] data;
	} cap_word_t;

	// per frame result, packed into the low bits of a status word
	typedef struct packed {
		logic [LINE_CNT_WIDTH-1:0] line_count;
		logic                      line_len_err;
		logic                      line_count_err;
		logic                      overflow;
	} frame_status_t;

endpackage

`default_nettype wire

//--- src/pixel_packer.sv
/* pixel packer: four sensor pixels per capture word,
   tags first word of a frame and last word of every line */
`timescale 1ns/1ps
`default_nettype none

module pixel_packer (
	input  logic                    clk_in,
	input  logic                    i_rst_n,
	input  capture_pkg::sensor_in_t i_sensor,
	output capture_pkg::cap_word_t  o_word,
	output logic                    o_word_valid
);
	import capture_pkg::*;

	localparam int LANE_W = $clog2(PIX_PER_WORD);
	localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(PIX_PER_WORD - 1);

	// registered copies of the sensor stream
	logic                  fval_d;
	logic                  lval_d;
	logic [PIX_WIDTH-1:0]  pix_d;
	// byte lanes of the word under construction
	logic [LANE_W-1:0]     lane_cnt;
	logic [WORD_WIDTH-1:0] lane_sr;
	logic [WORD_WIDTH-1:0] lane_sr_nxt;
	logic [LANE_W-1:0]     pad_lanes;
	logic                  sof_pend;
	logic                  pix_ok_d;
	logic                  line_end;
	logic                  frame_start;
	logic                  emit;

	// ----------------------------------------------------------------------
	// edge detection
	// ----------------------------------------------------------------------

	// pixel in pix_d is a real pixel
	assign pix_ok_d    = fval_d & lval_d;
	// live input already dropped, so pix_d is the last pixel of the line
	assign line_end    = pix_ok_d & ~(i_sensor.fval & i_sensor.lval);
	assign frame_start = i_sensor.fval & ~fval_d;

	always_ff @(posedge clk_in or negedge i_rst_n) begin
		if (!i_rst_n) begin
			fval_d <= 1'b0;
			lval_d <= 1'b0;
		end else begin
			fval_d <= i_sensor.fval;
			lval_d <= i_sensor.lval;
		end
	end

	always_ff @(posedge clk_in) begin
		pix_d <= i_sensor.pix;
	end

	// ----------------------------------------------------------------------
	// lane packing
	// ----------------------------------------------------------------------

	// new pixel enters at the top, older pixels move toward the low byte
	assign lane_sr_nxt = {pix_d, lane_sr[WORD_WIDTH-1:PIX_WIDTH]};
	// unused lanes of a short word
	assign pad_lanes   = LAST_LANE - lane_cnt;
	// word done on the last lane or at line end
	assign emit        = pix_ok_d & ((lane_cnt == LAST_LANE) | line_end);

	always_ff @(posedge clk_in) begin
		if (pix_ok_d) begin
			lane_sr <= lane_sr_nxt;
		end
	end

	always_ff @(posedge clk_in or negedge i_rst_n) begin
		if (!i_rst_n) begin
			lane_cnt     <= '0;
			sof_pend     <= 1'b0;
			o_word_valid <= 1'b0;
		end else begin
			o_word_valid <= emit;
			if (emit) begin
				lane_cnt <= '0;
			end else if (pix_ok_d) begin
				lane_cnt <= lane_cnt + 1'b1;
			end
			// armed at fval rise, spent on the first word
			if (frame_start) begin
				sof_pend <= 1'b1;
			end else if (emit) begin
				sof_pend <= 1'b0;
			end
		end
	end

	// output word, shifted down so pixel 0 lands in the low byte
	always_ff @(posedge clk_in) begin
		if (emit) begin
			o_word.kind <= WORD_PIX;
			o_word.sof  <= sof_pend;
			o_word.eol  <= line_end;
			o_word.data <= lane_sr_nxt >> (pad_lanes * PIX_WIDTH);
		end
	end

	// sensor protocol: no line outside a frame
	a_lval_in_frame: assert property (@(posedge clk_in) disable iff (!i_rst_n)
		i_sensor.lval |-> i_sensor.fval);

endmodule

`default_nettype wire

//--- src/frame_timing_check.sv
/* frame timing check: pixels per line and lines per frame
   against the expected geometry, status pulse at frame end */
`timescale 1ns/1ps
`default_nettype none

module frame_timing_check #(
	parameter int LINE_PIX    = 16,
	parameter int FRAME_LINES = 4
) (
	input  logic                       clk_in,
	input  logic                       i_rst_n,
	input  capture_pkg::sensor_in_t    i_sensor,
	output capture_pkg::frame_status_t o_status,
	output logic                       o_status_valid
);
	import capture_pkg::*;

	// one spare code so any long line saturates away from LINE_PIX
	localparam int PIX_CNT_W = $clog2(LINE_PIX + 2);

	logic                      fval_d;
	logic                      lval_d;
	logic [PIX_CNT_W-1:0]      pix_cnt;
	logic [LINE_CNT_WIDTH-1:0] line_cnt;
	logic [LINE_CNT_WIDTH-1:0] line_cnt_nxt;
	logic                      len_err;
	logic                      len_err_nxt;
	logic                      pix_ok;
	logic                      line_end;
	logic                      frame_end;

	// ----------------------------------------------------------------------
	// stream edges
	// ----------------------------------------------------------------------

	assign pix_ok    = i_sensor.fval & i_sensor.lval;
	// line was active last sample, not now
	assign line_end  = fval_d & lval_d & ~pix_ok;
	// fval seen low after high
	assign frame_end = fval_d & ~i_sensor.fval;

	always_ff @(posedge clk_in or negedge i_rst_n) begin
		if (!i_rst_n) begin
			fval_d <= 1'b0;
			lval_d <= 1'b0;
		end else begin
			fval_d <= i_sensor.fval;
			lval_d <= i_sensor.lval;
		end
	end

	// ----------------------------------------------------------------------
	// counters
	// ----------------------------------------------------------------------

	// count and error including a line closing this very cycle
	assign line_cnt_nxt = (line_end && (line_cnt != '1)) ? line_cnt + 1'b1 : line_cnt;
	assign len_err_nxt  = len_err | (line_end & (pix_cnt != PIX_CNT_W'(LINE_PIX)));

	always_ff @(posedge clk_in or negedge i_rst_n) begin
		if (!i_rst_n) begin
			pix_cnt  <= '0;
			line_cnt <= '0;
			len_err  <= 1'b0;
		end else begin
			// pixels of the current line, saturating
			if (line_end) begin
				pix_cnt <= '0;
			end else if (pix_ok && (pix_cnt != '1)) begin
				pix_cnt <= pix_cnt + 1'b1;
			end
			// lines and sticky length error, cleared per frame
			if (frame_end) begin
				line_cnt <= '0;
				len_err  <= 1'b0;
			end else begin
				line_cnt <= line_cnt_nxt;
				len_err  <= len_err_nxt;
			end
		end
	end

	// ----------------------------------------------------------------------
	// status
	// ----------------------------------------------------------------------

	always_ff @(posedge clk_in or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_status_valid <= 1'b0;
		end else begin
			o_status_valid <= frame_end;
		end
	end

	// overflow belongs to the framer, left clear here
	always_ff @(posedge clk_in) begin
		if (frame_end) begin
			o_status.line_count     <= line_cnt_nxt;
			o_status.line_len_err   <= len_err_nxt;
			o_status.line_count_err <= line_cnt_nxt != LINE_CNT_WIDTH'(FRAME_LINES);
			o_status.overflow       <= 1'b0;
		end
	end

	// source keeps lval low for a while before closing the frame
	a_line_before_frame: assert property (@(posedge clk_in) disable iff (!i_rst_n)
		frame_end |-> !lval_d);

endmodule

`default_nettype wire

//--- output_framer/word_fifo.sv
/* synchronous register FIFO for capture words
   with occupancy count and full / empty flags */
`timescale 1ns/1ps
`default_nettype none

module word_fifo #(
	parameter int FIFO_DEPTH = 32
) (
	input  logic                   clk_in,
	input  logic                   i_rst_n,
	input  logic                   i_push,
	input  capture_pkg::cap_word_t i_din,
	input  logic                   i_pop,
	output capture_pkg::cap_word_t o_dout,
	output logic                   o_empty,
	output logic                   o_full
);
	import capture_pkg::*;

	localparam int AW = $clog2(FIFO_DEPTH);
	localparam int CW = $clog2(FIFO_DEPTH + 1);
	localparam logic [AW-1:0] LAST_IDX = AW'(FIFO_DEPTH - 1);

	cap_word_t       mem [FIFO_DEPTH];
	logic [AW-1:0]   wr_ptr;
	logic [AW-1:0]   rd_ptr;
	logic [CW-1:0]   count;

	assign o_empty = (count == '0);
	assign o_full  = (count == CW'(FIFO_DEPTH));
	// head word, valid while not empty
	assign o_dout  = mem[rd_ptr];

	always_ff @(posedge clk_in) begin
		if (i_push) begin
			mem[wr_ptr] <= i_din;
		end
	end

	// pointers wrap at the depth, not only at a power of two
	always_ff @(posedge clk_in or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (i_push) begin
				wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
			end
			if (i_pop) begin
				rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CW'(i_push) - CW'(i_pop);
		end
	end

	a_no_push_full: assert property (@(posedge clk_in) disable iff (!i_rst_n)
		o_full |-> !i_push);
	a_no_pop_empty: assert property (@(posedge clk_in) disable iff (!i_rst_n)
		o_empty |-> !i_pop);

endmodule

`default_nettype wire

//--- output_framer/output_framer.sv
/* output framer: merges pixel words and frame status into the FIFO,
   drains it under credit flow control */
`timescale 1ns/1ps
`default_nettype none

module output_framer #(
	parameter int FIFO_DEPTH  = 32,
	parameter int MAX_CREDITS = 8
) (
	input  logic                       clk_in,
	input  logic                       i_rst_n,
	input  capture_pkg::cap_word_t     i_pix_word,
	input  logic                       i_pix_word_valid,
	input  capture_pkg::frame_status_t i_status,
	input  logic                       i_status_valid,
	input  logic                       i_credit,
	output capture_pkg::cap_word_t     o_word,
	output logic                       o_word_valid
);
	import capture_pkg::*;

	localparam int CRED_W = $clog2(MAX_CREDITS + 1);

	framer_state_e     state;
	framer_state_e     state_nxt;
	frame_status_t     hold_status;
	logic              ovf;
	logic              pix_drop;
	logic              status_queued;
	logic              push;
	cap_word_t         push_word;
	logic              pop;
	cap_word_t         fifo_dout;
	logic              fifo_empty;
	logic              fifo_full;
	logic [CRED_W-1:0] credit_cnt;

	// status into the low bits of a word, overflow merged in
	function automatic cap_word_t status_word(input frame_status_t st, input logic of);
		frame_status_t s;
		cap_word_t w;
		s          = st;
		s.overflow = of;
		w.kind     = WORD_STATUS;
		w.sof      = 1'b0;
		w.eol      = 1'b0;
		w.data     = WORD_WIDTH'(s);
		return w;
	endfunction

	// ----------------------------------------------------------------------
	// merge FSM
	// ----------------------------------------------------------------------

	always_comb begin
		state_nxt     = state;
		push          = 1'b0;
		push_word     = i_pix_word;
		pix_drop      = 1'b0;
		status_queued = 1'b0;
		case (state)
			IDLE: begin
				if (i_pix_word_valid) begin
					// pixel word has the slot, status waits a cycle
					push     = ~fifo_full;
					pix_drop = fifo_full;
					if (i_status_valid) begin
						state_nxt = HOLD_STATUS;
					end
				end else if (i_status_valid) begin
					if (fifo_full) begin
						state_nxt = HOLD_STATUS;
					end else begin
						push          = 1'b1;
						push_word     = status_word(i_status, ovf);
						status_queued = 1'b1;
					end
				end
			end
			HOLD_STATUS: begin
				// status first, any pixel word now is lost
				pix_drop = i_pix_word_valid;
				if (!fifo_full) begin
					push          = 1'b1;
					push_word     = status_word(hold_status, ovf);
					status_queued = 1'b1;
					state_nxt     = IDLE;
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk_in or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= IDLE;
			ovf   <= 1'b0;
		end else begin
			state <= state_nxt;
			// a drop in the queuing cycle counts for the next frame
			ovf   <= (ovf & ~status_queued) | pix_drop;
		end
	end

	always_ff @(posedge clk_in) begin
		if ((state == IDLE) && i_status_valid) begin
			hold_status <= i_status;
		end
	end

	word_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) word_fifo_inst (
		.clk_in  (clk_in),
		.i_rst_n (i_rst_n),
		.i_push  (push),
		.i_din   (push_word),
		.i_pop   (pop),
		.o_dout  (fifo_dout),
		.o_empty (fifo_empty),
		.o_full  (fifo_full)
	);

	// ----------------------------------------------------------------------
	// credit gated output
	// ----------------------------------------------------------------------

	assign pop = ~fifo_empty & (credit_cnt != '0);

	always_ff @(posedge clk_in or negedge i_rst_n) begin
		if (!i_rst_n) begin
			credit_cnt   <= CRED_W'(MAX_CREDITS);
			o_word_valid <= 1'b0;
		end else begin
			credit_cnt   <= credit_cnt + CRED_W'(i_credit) - CRED_W'(pop);
			o_word_valid <= pop;
		end
	end

	always_ff @(posedge clk_in) begin
		if (pop) begin
			o_word <= fifo_dout;
		end
	end

	// receiver never returns more than it was sent
	a_credit_max: assert property (@(posedge clk_in) disable iff (!i_rst_n)
		credit_cnt <= CRED_W'(MAX_CREDITS));

endmodule

`default_nettype wire

//--- src/video_capture_top.sv
/* video capture top: packer and timing check side by side
   on the sensor stream, results merged by the output framer */
`timescale 1ns/1ps
`default_nettype none

module video_capture_top #(
	parameter int LINE_PIX    = 16,
	parameter int FRAME_LINES = 4,
	parameter int FIFO_DEPTH  = 32,
	parameter int MAX_CREDITS = 8
) (
	input  logic                    clk_in,
	input  logic                    i_rst_n,
	input  capture_pkg::sensor_in_t i_sensor,
	input  logic                    i_credit,
	output capture_pkg::cap_word_t  o_word,
	output logic                    o_word_valid
);
	import capture_pkg::*;

	// packer to framer
	cap_word_t     pix_word;
	logic          pix_word_valid;
	// timing check to framer
	frame_status_t frame_status;
	logic          frame_status_valid;

	pixel_packer pixel_packer_inst (
		.clk_in       (clk_in),
		.i_rst_n      (i_rst_n),
		.i_sensor     (i_sensor),
		.o_word       (pix_word),
		.o_word_valid (pix_word_valid)
	);

	frame_timing_check #(
		.LINE_PIX    (LINE_PIX),
		.FRAME_LINES (FRAME_LINES)
	) frame_timing_check_inst (
		.clk_in         (clk_in),
		.i_rst_n        (i_rst_n),
		.i_sensor       (i_sensor),
		.o_status       (frame_status),
		.o_status_valid (frame_status_valid)
	);

	output_framer #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.MAX_CREDITS (MAX_CREDITS)
	) output_framer_inst (
		.clk_in           (clk_in),
		.i_rst_n          (i_rst_n),
		.i_pix_word       (pix_word),
		.i_pix_word_valid (pix_word_valid),
		.i_status         (frame_status),
		.i_status_valid   (frame_status_valid),
		.i_credit         (i_credit),
		.o_word           (o_word),
		.o_word_valid     (o_word_valid)
	);

endmodule

`default_nettype wire

//--- testbench/tb_stream_monitor.sv
/* stream monitor: collects output words, checks credit discipline
   and that each status word closes its frame */
`timescale 1ns/1ps
`default_nettype none

module tb_stream_monitor #(
	parameter int MAX_CREDITS = 8
) (
	input  logic                    clk_in,
	input  logic                    i_rst_n,
	input  capture_pkg::sensor_in_t i_sensor,
	input  logic                    i_credit,
	input  capture_pkg::cap_word_t  i_word,
	input  logic                    i_word_valid,
	output int                      o_violations
);
	import capture_pkg::*;

	// every received word in arrival order, read by the testbench
	cap_word_t rx_q[$];
	// sent words not yet paid back by a credit
	int        outstanding;
	int        frames_ended;
	int        status_seen;
	logic      frame_open;
	logic      fval_d;

	// ----------------------------------------------------------------------
	// sampled on the rising edge, DUT outputs are stable there
	// ----------------------------------------------------------------------

	always @(posedge clk_in or negedge i_rst_n) begin : watch
		int nxt;
		if (!i_rst_n) begin
			outstanding  = 0;
			frames_ended = 0;
			status_seen  = 0;
			frame_open   = 1'b0;
			fval_d       = 1'b0;
			o_violations = 0;
		end else begin
			// input tap, a frame closes when fval falls
			if (fval_d && !i_sensor.fval) begin
				frames_ended++;
			end
			fval_d = i_sensor.fval;
			// credit bookkeeping
			nxt = outstanding + int'(i_word_valid) - int'(i_credit);
			if (i_word_valid && (nxt > MAX_CREDITS)) begin
				$display("monitor: word sent at %0t with %0d words outstanding, limit %0d",
					$time, nxt, MAX_CREDITS);
				o_violations++;
			end
			if (nxt < 0) begin
				$display("monitor: credit returned at %0t with no word outstanding", $time);
				o_violations++;
			end
			outstanding = nxt;
			if (i_word_valid) begin
				rx_q.push_back(i_word);
				if (i_word.kind == WORD_STATUS) begin
					if (status_seen >= frames_ended) begin
						$display("monitor: status word at %0t before its frame ended", $time);
						o_violations++;
					end
					status_seen++;
					frame_open = 1'b0;
				end else if (i_word.sof) begin
					if (frame_open) begin
						$display("monitor: new frame at %0t while the last one lacks a status word",
							$time);
						o_violations++;
					end
					frame_open = 1'b1;
				end else if (!frame_open) begin
					// pixel word after the status that closed its frame
					$display("monitor: pixel word at %0t after its frame's status word", $time);
					o_violations++;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_video_capture.sv
/* capture testbench: clock, reset, sensor frames, credit return,
   reference words and status, checks and summary */
`timescale 1ns/1ps
`default_nettype none

module tb_video_capture;
	import capture_pkg::*;

	localparam int LINE_PIX    = 16;
	localparam int FRAME_LINES = 4;
	localparam int FIFO_DEPTH  = 32;
	localparam int MAX_CREDITS = 8;
	// cycles any wait may take
	localparam int WAIT_LIMIT  = 3000;

	logic                 clk_in;
	logic                 rst_n;
	sensor_in_t           sensor;
	logic                 credit;
	cap_word_t            word;
	logic                 word_valid;
	int                   violations;
	logic                 hold_credits;
	int                   credits_owed;
	// frame geometry and pixels of the frame being driven
	int                   line_len[$];
	logic [PIX_WIDTH-1:0] pix_q[$];
	cap_word_t            exp_q[$];
	int                   rx_base;
	int                   errors;
	int                   err_mark;
	int                   tests_run;
	int                   tests_failed;
	logic                 timed_out;

	video_capture_top #(
		.LINE_PIX    (LINE_PIX),
		.FRAME_LINES (FRAME_LINES),
		.FIFO_DEPTH  (FIFO_DEPTH),
		.MAX_CREDITS (MAX_CREDITS)
	) video_capture_top_inst (
		.clk_in       (clk_in),
		.i_rst_n      (rst_n),
		.i_sensor     (sensor),
		.i_credit     (credit),
		.o_word       (word),
		.o_word_valid (word_valid)
	);

	tb_stream_monitor #(
		.MAX_CREDITS (MAX_CREDITS)
	) tb_stream_monitor_inst (
		.clk_in       (clk_in),
		.i_rst_n      (rst_n),
		.i_sensor     (sensor),
		.i_credit     (credit),
		.i_word       (word),
		.i_word_valid (word_valid),
		.o_violations (violations)
	);

	initial begin
		clk_in = 1'b0;
		forever #2 clk_in = ~clk_in;
	end

	// ----------------------------------------------------------------------
	// receiver: one credit back per word, random spacing
	// ----------------------------------------------------------------------

	initial begin
		int gap;
		gap          = 0;
		credits_owed = 0;
		credit       = 1'b0;
		forever begin
			@(posedge clk_in);
			if (word_valid) begin
				credits_owed++;
			end
			if (!hold_credits && (credits_owed > 0) && (gap == 0)) begin
				credit <= 1'b1;
				credits_owed--;
				gap = $urandom % 6;
			end else begin
				credit <= 1'b0;
				if (!hold_credits && (gap > 0)) begin
					gap--;
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------

	function automatic int total_errors();
		return errors + violations;
	endfunction

	function automatic int rx_count();
		return tb_stream_monitor_inst.rx_q.size() - rx_base;
	endfunction

	function automatic cap_word_t rx_word(input int idx);
		return tb_stream_monitor_inst.rx_q[rx_base + idx];
	endfunction

	function automatic int status_count();
		int n;
		cap_word_t w;
		n = 0;
		for (int i = 0; i < rx_count(); i++) begin
			w = rx_word(i);
			if (w.kind == WORD_STATUS) begin
				n++;
			end
		end
		return n;
	endfunction

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s: got %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	function automatic void set_geometry(input int lines, input int len);
		line_len.delete();
		repeat (lines) line_len.push_back(len);
	endfunction

	function automatic void fill_pixels();
		pix_q.delete();
		foreach (line_len[l]) begin
			repeat (line_len[l]) pix_q.push_back(PIX_WIDTH'($urandom));
		end
	endfunction

	// expected words of one frame, appended to exp_q
	function automatic void compute_reference(input logic ovf);
		int p;
		logic len_err;
		logic cnt_err;
		cap_word_t w;
		p       = 0;
		len_err = 1'b0;
		foreach (line_len[l]) begin
			if (line_len[l] != LINE_PIX) begin
				len_err = 1'b1;
			end
			for (int i = 0; i < line_len[l]; i += PIX_PER_WORD) begin
				w      = '0;
				w.kind = WORD_PIX;
				w.sof  = (p == 0);
				w.eol  = (i + PIX_PER_WORD >= line_len[l]);
				// first pixel low, missing lanes stay zero
				for (int lane = 0; (lane < PIX_PER_WORD) && (i + lane < line_len[l]); lane++) begin
					w.data[lane*PIX_WIDTH +: PIX_WIDTH] = pix_q[p];
					p++;
				end
				exp_q.push_back(w);
			end
		end
		cnt_err = (line_len.size() != FRAME_LINES);
		w       = '0;
		w.kind  = WORD_STATUS;
		// line count, length error, count error, overflow from bit 14 down
		w.data  = {17'd0, LINE_CNT_WIDTH'(line_len.size()), len_err, cnt_err, ovf};
		exp_q.push_back(w);
	endfunction

	task automatic set_sensor(input logic fval, input logic lval, input logic [PIX_WIDTH-1:0] pix);
		sensor.fval <= fval;
		sensor.lval <= lval;
		sensor.pix  <= pix;
	endtask

	task automatic drive_frame();
		int p;
		p = 0;
		@(posedge clk_in);
		set_sensor(1'b1, 1'b0, '0);
		repeat (2) @(posedge clk_in);
		foreach (line_len[l]) begin
			for (int i = 0; i < line_len[l]; i++) begin
				set_sensor(1'b1, 1'b1, pix_q[p]);
				p++;
				@(posedge clk_in);
			end
			// line blanking, at least two cycles
			set_sensor(1'b1, 1'b0, '0);
			repeat (2 + $urandom % 3) @(posedge clk_in);
		end
		// frame blanking
		set_sensor(1'b0, 1'b0, '0);
		repeat (3 + $urandom % 3) @(posedge clk_in);
	endtask

	task automatic run_frame(input logic ovf);
		fill_pixels();
		compute_reference(ovf);
		drive_frame();
	endtask

	task automatic wait_for_status(input int n);
		int cycles;
		cycles = 0;
		while ((status_count() < n) && (cycles < WAIT_LIMIT)) begin
			@(negedge clk_in);
			cycles++;
		end
		if (status_count() < n) begin
			$display("timeout: %0d status words expected, %0d seen after %0d cycles",
				n, status_count(), cycles);
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_credits_home();
		int cycles;
		cycles = 0;
		while ((credits_owed != 0) && (cycles < WAIT_LIMIT)) begin
			@(negedge clk_in);
			cycles++;
		end
		if (credits_owed != 0) begin
			$display("timeout: %0d credits still owed after %0d cycles", credits_owed, cycles);
			timed_out = 1'b1;
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk_in);
	endtask

	task automatic clear_window();
		rx_base = tb_stream_monitor_inst.rx_q.size();
		exp_q.delete();
	endtask

	// exact match, or in-order prefix of pixel words plus the status word
	task automatic compare_words(input logic prefix);
		int n;
		int n_exp;
		n     = rx_count();
		n_exp = exp_q.size();
		if (!prefix) begin
			check_eq(n, n_exp, "received word count");
			for (int i = 0; (i < n) && (i < n_exp); i++) begin
				check_eq(rx_word(i), exp_q[i], $sformatf("word %0d", i));
			end
		end else begin
			check_eq((n >= 1) && (n < n_exp), 1'b1, "word count under overflow");
			for (int i = 0; (i < n - 1) && (i < n_exp - 1); i++) begin
				check_eq(rx_word(i), exp_q[i], $sformatf("pixel word %0d", i));
			end
			if (n >= 1) begin
				check_eq(rx_word(n - 1), exp_q[n_exp - 1], "status word last");
			end
		end
	endtask

	task automatic start_test();
		err_mark = total_errors();
		clear_window();
	endtask

	task automatic end_test(input string name);
		int n;
		n = total_errors() - err_mark;
		tests_run++;
		if ((n != 0) || timed_out) begin
			tests_failed++;
			$display("test %s: failed, %0d errors", name, n);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	// ----------------------------------------------------------------------
	// tests
	// ----------------------------------------------------------------------

	task automatic test_idle();
		int busy;
		start_test();
		busy = 0;
		repeat (50) begin
			@(negedge clk_in);
			if (word_valid) begin
				busy++;
			end
		end
		check_eq(busy, 0, "cycles with o_word_valid high before any frame");
		end_test("idle after reset");
	endtask

	task automatic test_nominal();
		cap_word_t w;
		start_test();
		set_geometry(4, 16);
		run_frame(1'b0);
		wait_for_status(1);
		idle_cycles(10);
		compare_words(1'b0);
		// tag pattern on its own
		for (int i = 0; i < rx_count() - 1; i++) begin
			w = rx_word(i);
			check_eq(w.sof, i == 0, $sformatf("sof of word %0d", i));
			check_eq(w.eol, (i % 4) == 3, $sformatf("eol of word %0d", i));
		end
		end_test("nominal 4x16 frame");
	endtask

	task automatic test_short_line();
		cap_word_t w;
		start_test();
		set_geometry(4, 16);
		line_len[2] = 14;
		run_frame(1'b0);
		wait_for_status(1);
		idle_cycles(10);
		compare_words(1'b0);
		// last word of line 2 holds two pixels
		if (rx_count() > 11) begin
			w = rx_word(11);
			check_eq(w.data[31:16], 16'h0, "padding of short line word");
			check_eq(w.eol, 1'b1, "eol of short line word");
		end
		end_test("short line");
	endtask

	task automatic test_short_frame();
		start_test();
		set_geometry(3, 16);
		run_frame(1'b0);
		wait_for_status(1);
		idle_cycles(10);
		compare_words(1'b0);
		end_test("three line frame");
	endtask

	task automatic test_random_credits();
		start_test();
		repeat (3) begin
			set_geometry(4, 16);
			run_frame(1'b0);
		end
		wait_for_status(3);
		idle_cycles(10);
		compare_words(1'b0);
		end_test("three frames, random credits");
	endtask

	task automatic test_overflow();
		start_test();
		wait_credits_home();
		hold_credits <= 1'b1;
		set_geometry(4, 64);
		run_frame(1'b1);
		repeat (20) @(posedge clk_in);
		hold_credits <= 1'b0;
		wait_for_status(1);
		idle_cycles(10);
		compare_words(1'b1);
		// next frame must come through clean
		clear_window();
		set_geometry(4, 16);
		run_frame(1'b0);
		wait_for_status(1);
		idle_cycles(10);
		compare_words(1'b0);
		end_test("overflow and recovery");
	endtask

	initial begin
		void'($urandom(32'h5660));
		rst_n        = 1'b0;
		sensor       = '0;
		hold_credits = 1'b0;
		errors       = 0;
		err_mark     = 0;
		tests_run    = 0;
		tests_failed = 0;
		timed_out    = 1'b0;
		rx_base      = 0;
		repeat (16) @(posedge clk_in);
		rst_n <= 1'b1;
		test_idle();
		if (!timed_out) test_nominal();
		if (!timed_out) test_short_line();
		if (!timed_out) test_short_frame();
		if (!timed_out) test_random_credits();
		if (!timed_out) test_overflow();
		$display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
			total_errors());
		if ((total_errors() == 0) && !timed_out) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
common/capture_pkg.sv
src/pixel_packer.sv
src/frame_timing_check.sv
output_framer/word_fifo.sv
output_framer/output_framer.sv
src/video_capture_top.sv
testbench/tb_stream_monitor.sv
testbench/tb_video_capture.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the capture testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_video_capture \
	-f filelist.f

out="$(./obj_dir/Vtb_video_capture)"
echo "$out"

if grep -qx "Simulation finished: PASS" <<< "$out"; then
	exit 0
else
	exit 1
fi
